// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_bch_dec
RTL_TOP   ?= bch_dec_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Checks failed
PASS_MSG  ?= All checks passed
VFLAGS    ?= --timing --assert

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: build
	-$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bch_chien.sv
`timescale 1ns/1ps
`default_nettype none

module bch_chien import bch_pkg::*; #(
	parameter int T = 2
) (
	input  wire       clk,
	input  wire       arst_n,
	input  wire       start,
	input  wire syn_t sigma,
	output logic      ready,
	output gf_t       ch1,   // S1 * alpha^-j in position j
	output gf_t       ch3,   // S3 * alpha^-3j in position j
	output logic      first,
	output logic      last,
	output logic      valid
);

	localparam gf_t ALPHA_INV1 = gf_alpha_pow(-1);
	localparam gf_t ALPHA_INV3 = gf_alpha_pow(-3);

	logic load;                 // terms hold S for one cycle before position 0
	logic [$clog2(N)-1:0] pos;  // current codeword position
	logic go;

	assign go    = start && ready;
	assign ready = !load && !valid;
	assign first = valid && pos == '0;
	assign last  = valid && pos == N - 1;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			load  <= 1'b0;
			valid <= 1'b0;
			pos   <= '0;
		end else begin
			load <= go;
			if (load) begin
				valid <= 1'b1;
				pos   <= '0;
			end else if (valid) begin
				pos <= pos + 1'b1;
				if (pos == N - 1)
					valid <= 1'b0; // exactly N positions
			end
		end
	end

	// step both terms once per emitted position
	always_ff @(posedge clk) begin
		if (go) begin
			ch1 <= sigma.s1;
			ch3 <= (T == 2) ? sigma.s3 : gf_t'(0);
		end else if (valid) begin
			ch1 <= gf_mul(ch1, ALPHA_INV1);
			ch3 <= gf_mul(ch3, ALPHA_INV3);
		end
	end

	a_burst_len: assert property (@(posedge clk) disable iff (!arst_n)
		go |-> ##2 valid [*N] ##1 !valid);

endmodule

`default_nettype wire

// File: bch_corrector.sv
`timescale 1ns/1ps
`default_nettype none

module bch_corrector import bch_pkg::*; (
	input  wire             clk,
	input  wire             arst_n,
	input  wire             wr_en,
	input  wire code_word_t wr_word,
	input  wire             flip,
	input  wire             out_first,
	input  wire             out_valid,
	input  wire err_class_e err_count,
	output logic            out_bit
);

	code_word_t buf_q [2]; // raw words waiting for their search
	logic wr_ptr;
	logic rd_ptr;
	logic [1:0] count;
	code_word_t sh;        // word being emitted, bit 0 is next
	logic raw;

	// first bit comes straight from the buffer head
	assign raw     = out_first ? buf_q[rd_ptr][0] : sh[0];
	assign out_bit = raw ^ (flip && err_count != ERR_MANY); // many: pass raw

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			count  <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= ~wr_ptr;
			if (out_first)
				rd_ptr <= ~rd_ptr; // pop oldest
			count <= count + {1'b0, wr_en} - {1'b0, out_first};
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			buf_q[wr_ptr] <= wr_word;
		if (out_first)
			sh <= buf_q[rd_ptr] >> 1;
		else if (out_valid)
			sh <= sh >> 1;
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
		wr_en |-> count != 2'd2);
	a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
		out_first |-> count != 2'd0); // every burst has a stored word

endmodule

`default_nettype wire

// File: bch_dec_checker.sv
`timescale 1ns/1ps
`default_nettype none

module bch_dec_checker import bch_pkg::*; (
	input  wire             clk,
	input  wire             arst_n,
	input  wire             start,
	input  wire             ready,
	input  wire             push,       // one expected word per start
	input  wire code_word_t push_word,
	input  wire err_class_e push_class,
	input  wire             out_valid,
	input  wire             out_first,
	input  wire             out_last,
	input  wire             out_bit,
	input  wire err_class_e err_count,
	output int              checked,
	output int              failures
);

	code_word_t exp_word_q [$];  // oldest word at the front
	err_class_e exp_class_q [$];
	code_word_t got = '0;        // bit j filled in burst cycle j
	err_class_e burst_class = ERR_NONE;
	logic in_burst = 1'b0;
	logic accepted = 1'b0;       // start taken on the last rising edge
	int nbits = 0;
	int n_checked = 0;
	int n_failures = 0;

	assign checked  = n_checked;
	assign failures = n_failures;

	task automatic report_problem(string what);
		$display("Problem at %0t: %s", $time, what);
		n_failures++;
	endtask

	task automatic finish_word();
		code_word_t exp_word;
		err_class_e exp_class;
		if (nbits != N)
			report_problem($sformatf("burst held %0d bits instead of %0d", nbits, N));
		if (exp_word_q.size() == 0) begin
			report_problem("output burst arrived with no word outstanding");
		end else begin
			exp_word  = exp_word_q.pop_front();
			exp_class = exp_class_q.pop_front();
			if (got !== exp_word || burst_class !== exp_class) begin
				$display("Error at %0t: word %0d got %h %s, expected %h %s", $time, n_checked,
					got, burst_class.name(), exp_word, exp_class.name());
				n_failures++;
			end else begin
				$display("word %0d ok: %h %s", n_checked, got, burst_class.name());
			end
		end
		n_checked++;
		in_burst = 1'b0;
	endtask

	always @(posedge clk) begin
		if (push) begin
			exp_word_q.push_back(push_word);
			exp_class_q.push_back(push_class);
		end
		accepted <= arst_n && start && ready;
	end

	// outputs move on the rising edge, so look at them mid cycle
	always @(negedge clk) begin
		if (!arst_n) begin
			if (out_valid || out_first || out_last)
				report_problem("output strobe high while in reset");
			if (!ready)
				report_problem("ready low while in reset");
			in_burst = 1'b0;
		end else begin
			if (accepted && ready)
				report_problem("ready stayed high after an accepted start");
			if ((out_first || out_last) && !out_valid)
				report_problem("out_first or out_last without out_valid");
			if (out_first) begin
				if (in_burst)
					report_problem("out_first came before out_last of the previous burst");
				in_burst    = 1'b1;
				nbits       = 0;
				got         = '0;
				burst_class = err_count; // class must hold to the last bit
			end
			if (out_valid && !in_burst) begin
				report_problem("out_valid high outside a burst");
			end else if (out_valid) begin
				got = got | (code_word_t'(out_bit) << nbits);
				nbits++;
				if (err_count !== burst_class)
					report_problem("err_count changed inside a burst");
				if (out_last)
					finish_word();
				else if (nbits >= N) begin
					report_problem("burst reached 31 bits without out_last");
					in_burst = 1'b0;
				end
			end else if (in_burst) begin
				report_problem("out_valid dropped before out_last");
				in_burst = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: bch_dec_top.sv
`timescale 1ns/1ps
`default_nettype none

module bch_dec_top import bch_pkg::*; #(
	parameter int T = 2 // 1: 26 data bits, 2: 21 data bits
) (
	input  wire             clk,
	input  wire             arst_n,
	input  wire             start,
	input  wire code_word_t codeword,
	output logic            ready,
	output logic            out_valid,
	output logic            out_first,
	output logic            out_last,
	output logic            out_bit,
	output err_class_e      err_count
);

	syn_t syn;
	logic syn_valid;
	logic syn_take;
	logic wr_en;
	code_word_t wr_word;
	logic flip;

	bch_syndrome #(.T(T)) u_syndrome (
		.clk(clk), .arst_n(arst_n), .start(start), .codeword(codeword),
		.syn_take(syn_take), .ready(ready), .syn_valid(syn_valid), .syn(syn),
		.wr_en(wr_en), .wr_word(wr_word)
	);

	bch_error_dec #(.T(T)) u_error_dec (
		.clk(clk), .arst_n(arst_n), .syn_valid(syn_valid), .syn(syn),
		.syn_take(syn_take), .flip(flip), .out_first(out_first),
		.out_last(out_last), .out_valid(out_valid), .err_count(err_count)
	);

	bch_corrector u_corrector (
		.clk(clk), .arst_n(arst_n), .wr_en(wr_en), .wr_word(wr_word), .flip(flip),
		.out_first(out_first), .out_valid(out_valid), .err_count(err_count),
		.out_bit(out_bit)
	);

endmodule

`default_nettype wire

// File: bch_error_dec.sv
`timescale 1ns/1ps
`default_nettype none

module bch_error_dec import bch_pkg::*; #(
	parameter int T = 2
) (
	input  wire        clk,
	input  wire        arst_n,
	input  wire        syn_valid,
	input  wire syn_t  syn,
	output logic       syn_take,
	output logic       flip,      // error at the current output position
	output logic       out_first,
	output logic       out_last,
	output logic       out_valid,
	output err_class_e err_count  // held for the whole burst
);

	gf_t ch1;
	gf_t ch3;
	logic ch_ready;
	logic first_cycle; // chien terms still equal the raw syndromes

	assign syn_take = syn_valid && ch_ready; // only when search is idle

	bch_chien #(
		.T(T)
	) u_chien (
		.clk   (clk),
		.arst_n(arst_n),
		.start (syn_take),
		.sigma (syn),
		.ready (ch_ready),
		.ch1   (ch1),
		.ch3   (ch3),
		.first (out_first),
		.last  (out_last),
		.valid (out_valid)
	);

	always_ff @(posedge clk or negedge arst_n)
		if (!arst_n)
			first_cycle <= 1'b0;
		else
			first_cycle <= syn_take;

	if (T == 2) begin : g_dec
		// sigma(x) = 1 + S1 x + (S1^2 + S3/S1) x^2
		gf_t f1;
		gf_t f3;
		err_class_e cls;

		// try flipping: adding 1 to a scaled term adds alpha^j to the syndrome
		assign f1 = ch1 ^ gf_t'(!first_cycle);
		assign f3 = ch3 ^ gf_t'(!first_cycle);

		always_comb begin
			if (|f1)
				cls = (gf_cube(f1) == f3) ? ERR_ONE : ERR_TWO;
			else
				cls = (|f3) ? ERR_MANY : ERR_NONE;
		end

		assign flip = out_valid && err_count > cls; // flip lowered the count

		always_ff @(posedge clk or negedge arst_n)
			if (!arst_n)
				err_count <= ERR_NONE;
			else if (first_cycle)
				err_count <= cls; // unflipped class
	end else if (T == 1) begin : g_sec
		// sigma(x) = 1 + S1 x, error where S1 == alpha^j
		assign flip = out_valid && ch1 == gf_t'(1);

		always_ff @(posedge clk or negedge arst_n)
			if (!arst_n)
				err_count <= ERR_NONE;
			else if (first_cycle)
				err_count <= (|ch1) ? ERR_ONE : ERR_NONE;
	end else begin : g_bad
		$error("bch_error_dec supports T of 1 or 2 only");
	end

endmodule

`default_nettype wire

// File: bch_pkg.sv
`default_nettype none

package bch_pkg;

	localparam int M = 5;  // GF(2^5)
	localparam int N = 31; // 2^M - 1

	// x^5 + x^2 + 1, leading term implied
	localparam logic [M-1:0] GF_POLY = 5'b00101;

	typedef logic [M-1:0] gf_t;        // power basis, bit i is coeff of alpha^i
	typedef logic [N-1:0] code_word_t; // bit j is coeff of x^j

	typedef struct packed {
		gf_t s1;
		gf_t s3; // zero when T is 1
	} syn_t;

	typedef enum logic [1:0] {
		ERR_NONE = 2'd0,
		ERR_ONE  = 2'd1,
		ERR_TWO  = 2'd2,
		ERR_MANY = 2'd3 // uncorrectable
	} err_class_e;

	typedef enum logic [1:0] {
		SYN_IDLE,
		SYN_SHIFT,
		SYN_HOLD
	} syn_state_e;

	// shift and add, reduce on every doubling
	function automatic gf_t gf_mul(gf_t a, gf_t b);
		gf_t p;
		gf_t aa;
		p = '0;
		aa = a;
		for (int i = 0; i < M; i++) begin
			if (b[i])
				p = p ^ aa;
			aa = aa[M-1] ? ((aa << 1) ^ GF_POLY) : (aa << 1);
		end
		return p;
	endfunction

	function automatic gf_t gf_cube(gf_t a);
		return gf_mul(gf_mul(a, a), a);
	endfunction

	// alpha^e for constant tables, negative e wraps mod N
	function automatic gf_t gf_alpha_pow(int e);
		gf_t p;
		int k;
		p = gf_t'(1);
		k = ((e % N) + N) % N;
		for (int i = 0; i < k; i++)
			p = gf_mul(p, gf_t'(2));
		return p;
	endfunction

endpackage

`default_nettype wire

// File: bch_syndrome.sv
`timescale 1ns/1ps
`default_nettype none

module bch_syndrome import bch_pkg::*; #(
	parameter int T = 2
) (
	input  wire        clk,
	input  wire        arst_n,
	input  wire        start,
	input  wire code_word_t codeword,
	input  wire        syn_take,
	output logic       ready,
	output logic       syn_valid,
	output syn_t       syn,
	output logic       wr_en,    // word goes to corrector buffer on the same edge
	output code_word_t wr_word
);

	localparam gf_t ALPHA1 = gf_alpha_pow(1);
	localparam gf_t ALPHA3 = gf_alpha_pow(3);

	syn_state_e state;
	logic [$clog2(N)-1:0] cnt; // 0 is the latch cycle, 1..N are horner steps
	code_word_t sreg;          // msb leaves first
	gf_t s1;
	gf_t s3;
	logic shifting;

	assign ready     = state == SYN_IDLE;
	assign syn_valid = state == SYN_HOLD; // level until taken
	assign wr_en     = start && ready;
	assign wr_word   = codeword;
	assign shifting  = state == SYN_SHIFT && cnt != '0;

	assign syn = {s1, (T == 2) ? s3 : gf_t'(0)};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= SYN_IDLE;
			cnt   <= '0;
		end else begin
			case (state)
				SYN_IDLE: if (start) begin
					state <= SYN_SHIFT;
					cnt   <= '0;
				end
				SYN_SHIFT: begin
					cnt <= cnt + 1'b1;
					if (cnt == N)
						state <= SYN_HOLD; // last horner step done
				end
				SYN_HOLD: if (syn_take)
					state <= SYN_IDLE;
				default: state <= SYN_IDLE;
			endcase
		end
	end

	// s(x) <- s(x)*alpha^k + r_j for j = N-1 downto 0
	always_ff @(posedge clk) begin
		if (wr_en)
			sreg <= codeword;
		else if (shifting)
			sreg <= sreg << 1;
		if (state == SYN_SHIFT && cnt == '0) begin
			s1 <= '0; // latch cycle, clear accumulators
			s3 <= '0;
		end else if (shifting) begin
			s1 <= gf_mul(s1, ALPHA1) ^ gf_t'(sreg[N-1]);
			s3 <= gf_mul(s3, ALPHA3) ^ gf_t'(sreg[N-1]);
		end
	end

	a_start_ready: assert property (@(posedge clk) disable iff (!arst_n)
		start |-> ready);

endmodule

`default_nettype wire

// File: build.f
bch_pkg.sv
bch_syndrome.sv
bch_chien.sv
bch_error_dec.sv
bch_corrector.sv
bch_dec_top.sv
bch_dec_checker.sv
tb_bch_dec.sv

// File: tb_bch_dec.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bch_dec import bch_pkg::*; ();

	localparam int N_ENTRIES = 50;
	localparam int CYCLE_LIMIT = N_ENTRIES * 70 + 200;
	localparam logic [10:0] GEN = 11'h769; // product m1(x) * m3(x) (octal 3551)

	logic clk;
	logic arst_n;
	logic start;
	code_word_t codeword;
	logic ready;
	logic out_valid;
	logic out_first;
	logic out_last;
	logic out_bit;
	err_class_e err_count;
	logic push;              // hands the expected word to the checker
	code_word_t push_word;
	err_class_e push_class;
	int checked;
	int failures;
	int seed;
	int table_fails;
	int cycles;

	// stimulus table, one row per codeword
	logic [20:0] msg_tab [N_ENTRIES];
	code_word_t mask_tab [N_ENTRIES];
	err_class_e cls_tab [N_ENTRIES];
	int gap_tab [N_ENTRIES];   // idle cycles ahead of the start (0 for back to back)

	bch_dec_top #(.T(2)) u_bch_dec_top (
		.clk(clk), .arst_n(arst_n), .start(start), .codeword(codeword), .ready(ready),
		.out_valid(out_valid), .out_first(out_first), .out_last(out_last),
		.out_bit(out_bit), .err_count(err_count)
	);

	bch_dec_checker u_checker (
		.clk(clk), .arst_n(arst_n), .start(start), .ready(ready), .push(push),
		.push_word(push_word), .push_class(push_class), .out_valid(out_valid),
		.out_first(out_first), .out_last(out_last), .out_bit(out_bit),
		.err_count(err_count), .checked(checked), .failures(failures)
	);

	// carry-less product m(x) * g(x)
	function automatic code_word_t encode(logic [20:0] msg);
		code_word_t cw;
		cw = '0;
		for (int i = 0; i < 21; i++)
			if (msg[i])
				cw = cw ^ (code_word_t'(GEN) << i);
		return cw;
	endfunction

	function automatic code_word_t bit_at(int p);
		return code_word_t'(1) << p;
	endfunction

	function automatic logic [20:0] rand_msg();
		logic [31:0] r;
		r = $random(seed);
		return r[20:0];
	endfunction

	function automatic int rand_below(int n);
		logic [31:0] r;
		r = $random(seed);
		return int'(r[15:0]) % n;
	endfunction

	// class of an error pattern from S1 = e(alpha) and S3 = e(alpha^3)
	function automatic err_class_e predict_class(code_word_t e);
		gf_t s1;
		gf_t s3;
		s1 = '0;
		s3 = '0;
		for (int j = 0; j < N; j++)
			if (e[j]) begin
				s1 = s1 ^ gf_alpha_pow(j);
				s3 = s3 ^ gf_alpha_pow(3 * j);
			end
		if (s1 == '0)
			return (s3 == '0) ? ERR_NONE : ERR_MANY;
		return (gf_cube(s1) == s3) ? ERR_ONE : ERR_TWO;
	endfunction

	task automatic set_entry(int i, logic [20:0] msg, code_word_t mask, err_class_e cls);
		msg_tab[i]  = msg;
		mask_tab[i] = mask;
		cls_tab[i]  = cls;
		gap_tab[i]  = (i % 5 == 0) ? 20 : 0; // every fifth word after a pause
		if (predict_class(mask) != cls) begin
			$display("Table entry %0d: mask %h does not decode as %s", i, mask, cls.name());
			table_fails++;
		end
	endtask

	task automatic build_table();
		int w;
		int p1;
		int p2;
		set_entry(0, 21'h0a5f3c, '0, ERR_NONE);
		for (int j = 0; j < N; j++)
			set_entry(1 + j, rand_msg(), bit_at(j), ERR_ONE); // every single position
		set_entry(32, rand_msg(), bit_at(0) | bit_at(30), ERR_TWO);
		set_entry(33, rand_msg(), bit_at(0) | bit_at(1), ERR_TWO);
		set_entry(34, rand_msg(), bit_at(29) | bit_at(30), ERR_TWO);
		// 1 + alpha^2 + alpha^5 = 0, so S1 vanishes for these triples
		set_entry(35, rand_msg(), bit_at(0) | bit_at(2) | bit_at(5), ERR_MANY);
		set_entry(36, rand_msg(), bit_at(10) | bit_at(12) | bit_at(15), ERR_MANY);
		set_entry(37, rand_msg(), bit_at(25) | bit_at(27) | bit_at(30), ERR_MANY);
		for (int i = 38; i < N_ENTRIES; i++) begin
			w  = rand_below(3);
			p1 = rand_below(N);
			p2 = (p1 + 1 + rand_below(N - 1)) % N; // distinct from p1
			case (w)
				0: set_entry(i, rand_msg(), '0, ERR_NONE);
				1: set_entry(i, rand_msg(), bit_at(p1), ERR_ONE);
				default: set_entry(i, rand_msg(), bit_at(p1) | bit_at(p2), ERR_TWO);
			endcase
		end
	endtask

	task automatic send_word(int i);
		code_word_t clean;
		code_word_t sent;
		clean = encode(msg_tab[i]);
		sent  = clean ^ mask_tab[i];
		repeat (gap_tab[i]) @(negedge clk);
		while (!ready)
			@(negedge clk);
		start      = 1'b1;
		codeword   = sent;
		push       = 1'b1;
		push_word  = (cls_tab[i] == ERR_MANY) ? sent : clean; // uncorrectable comes back raw
		push_class = cls_tab[i];
		@(negedge clk);
		start = 1'b0;
		push  = 1'b0;
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, %0d of %0d words checked, %0d failures",
			cycles, checked, N_ENTRIES, failures + table_fails);
		$display("Checks failed");
		$finish;
	end

	initial begin
		arst_n      = 1'b0;
		start       = 1'b0;
		codeword    = '0;
		push        = 1'b0;
		push_word   = '0;
		push_class  = ERR_NONE;
		seed        = 32'h16ac_3ccd;
		table_fails = 0;
		build_table();
		repeat (16) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		for (int i = 0; i < N_ENTRIES; i++)
			send_word(i);
		while (checked < N_ENTRIES)
			@(negedge clk);
		repeat (4) @(negedge clk); // catch stray strobes after the last burst
		$display("%0d words sent, %0d checked, %0d failures", N_ENTRIES, checked,
			failures + table_fails);
		if (failures + table_fails == 0 && checked == N_ENTRIES)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire
